/* flist.f */
hw/scan_pkg.sv
hw/line_buf_if.sv
hw/line_writer.sv
hw/line_ram.sv
hw/pixel_reader.sv
hw/raster_timing.sv
hw/scan_doubler.sv
tests/scan_doubler_assertions.sv
tests/tb_scan_doubler.sv

/* run.sh */
#!/bin/sh
# build and run the scan doubler testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_scan_doubler -f flist.f

# pass or fail is decided by the pass line, not by the exit status
out=$(./obj_dir/Vtb_scan_doubler 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test passed'

/* tests/tb_scan_doubler.sv */
`timescale 1ns/10ps

module tb_scan_doubler import scan_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    // an input line takes two output lines, so an input frame is one output frame
    localparam int PAL_FRAME = 2 * (int'(PAL_H_MAX) + 1) * ((int'(PAL_V_MAX) + 1) / 2);
    localparam int NTSC_FRAME = 2 * (int'(NTSC_H_MAX) + 1) * ((int'(NTSC_V_MAX) + 1) / 2);
    localparam int HS_LEN = int'(PAL_HS_END - PAL_HS_STA);

    logic                  clk_dot4x;
    logic                  rst;
    logic [1:0]            chip;
    logic [RASTER_X_W-1:0] raster_x;
    logic [ADDR_W-1:0]     hires_raster_x;
    logic [RASTER_Y_W-1:0] raster_y;
    logic [COLOR_W-1:0]    pixel_color3;
    logic                  hsync;
    logic                  vsync;
    logic                  active;
    logic                  half_bright;
    logic [COLOR_W-1:0]    pixel_color4;

    logic [31:0] lfsr_state;

    // reference model state
    logic               m_live = 1'b0;
    // reset as seen by the last rising edge
    logic               m_in_rst;
    logic [1:0]         m_phase;
    logic               m_sel;
    logic [1:0]         m_chip;
    logic [H_W-1:0]     m_h;
    logic [V_W-1:0]     m_v;
    logic               m_hb;
    logic [COLOR_W-1:0] m_mem [NUM_BUFS][2**ADDR_W];
    // entries written since reset
    logic               m_ok [NUM_BUFS][2**ADDR_W];
    logic [COLOR_W-1:0] m_rd [NUM_BUFS];
    logic               m_rd_ok [NUM_BUFS];
    logic [COLOR_W-1:0] m_pix;
    logic               m_pix_ok;
    // {hsync, vsync, active, half_bright} on its way to the pins
    logic [3:0]         m_flags [PIPE_DELAY];

    // scoreboard
    int n_errors = 0;
    int n_cycles = 0;
    int n_tests = 0;
    int n_failed = 0;
    int low_len = 0;
    int last_fall = 0;
    logic prev_hsync = 1'b1;
    logic fall_seen = 1'b0;
    logic [1:0] fall_chip = CHIP_PAL;

    scan_doubler u_scan_doubler (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .chip           (chip),
        .raster_x       (raster_x),
        .hires_raster_x (hires_raster_x),
        .raster_y       (raster_y),
        .pixel_color3   (pixel_color3),
        .hsync          (hsync),
        .vsync          (vsync),
        .active         (active),
        .half_bright    (half_bright),
        .pixel_color4   (pixel_color4)
    );

    always #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // pin flags for one counter position
    function automatic logic [3:0] expected_flags(input logic [1:0] c, input logic [H_W-1:0] h,
                                                  input logic [V_W-1:0] v, input logic hb);
        logic ntsc;
        logic hs_low;
        logic vs_low;
        logic act;
        ntsc = (c == CHIP_NTSC);
        if (ntsc) begin
            hs_low = (h >= NTSC_HS_STA) && (h < NTSC_HS_END);
            vs_low = (v >= NTSC_VS_STA) && (v < NTSC_VS_END);
            act = (h >= NTSC_HA_STA) && (v >= NTSC_VA_STA);
        end else begin
            hs_low = (h >= PAL_HS_STA) && (h < PAL_HS_END);
            vs_low = (v >= PAL_VS_STA) && (v < PAL_VS_END);
            act = (h >= PAL_HA_STA) && (v <= PAL_VA_END);
        end
        return {~hs_low, ~vs_low, act, hb};
    endfunction

    // one clock of the model, same inputs the dut sees
    task automatic model_clock();
        logic [COLOR_W-1:0] rd_new [NUM_BUFS];
        logic               rd_ok_new [NUM_BUFS];
        logic               ntsc;
        logic               ls;
        logic [H_W-1:0]     h_max;
        logic [V_W-1:0]     v_max;
        m_in_rst = rst;
        ntsc = (m_chip == CHIP_NTSC);
        h_max = ntsc ? NTSC_H_MAX : PAL_H_MAX;
        v_max = ntsc ? NTSC_V_MAX : PAL_V_MAX;
        // ram read sees the contents before this clock's write
        for (int i = 0; i < NUM_BUFS; i++) begin
            rd_new[i] = m_mem[i][m_h];
            rd_ok_new[i] = m_ok[i][m_h];
        end
        if (rst) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                rd_ok_new[i] = 1'b0;
                for (int a = 0; a < 2**ADDR_W; a++) begin
                    m_ok[i][a] = 1'b0;
                end
            end
            for (int i = 0; i < PIPE_DELAY; i++) begin
                m_flags[i] = 4'b1100;
            end
            m_phase = 2'd0;
            m_sel = 1'b0;
            m_chip = CHIP_PAL;
            m_h = '0;
            m_v = PAL_V_MAX;
            m_hb = 1'b0;
            m_pix = '0;
            m_pix_ok = 1'b1;
            m_live = 1'b1;
        end else begin
            // output register picks the buffer not being filled
            m_pix = m_rd[!m_sel];
            m_pix_ok = m_rd_ok[!m_sel];
            for (int i = PIPE_DELAY - 1; i > 0; i--) begin
                m_flags[i] = m_flags[i-1];
            end
            m_flags[0] = expected_flags(m_chip, m_h, m_v, m_hb);
            m_mem[m_sel][hires_raster_x] = pixel_color3;
            m_ok[m_sel][hires_raster_x] = 1'b1;
            ls = (m_phase == 2'd1) && (raster_x == '0);
            if (m_h >= h_max) begin
                m_h = '0;
                if (m_v >= v_max) begin
                    m_v = '0;
                    m_hb = 1'b0;
                end else begin
                    m_v = m_v + 10'd1;
                    m_hb = !m_hb;
                end
            end else begin
                m_h = m_h + 11'd1;
            end
            // input frame start, next output line is line 0
            if (ls && (raster_y == '0)) begin
                m_v = (chip == CHIP_NTSC) ? NTSC_V_MAX : PAL_V_MAX;
                m_chip = chip;
            end
            if (ls) begin
                m_sel = !m_sel;
            end
            m_phase = m_phase + 2'd1;
        end
        for (int i = 0; i < NUM_BUFS; i++) begin
            m_rd[i] = rd_new[i];
            m_rd_ok[i] = rd_ok_new[i];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        n_errors++;
        $display("FAIL %s: expected %h, got %h at %0t ns", name, exp, act, $time);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("test %-22s ok", name);
        end else begin
            n_failed++;
            $display("test %-22s %0d mismatches", name, n_errors - errs_before);
        end
    endtask

    // one native frame, four clocks per dot
    // chip input moves to next_code halfway, the dut only takes it at the next frame start
    task automatic run_frame(input string name, input logic [1:0] code,
                             input logic [1:0] next_code);
        int dots;
        int lines;
        int errs_before;
        logic ntsc;
        errs_before = n_errors;
        ntsc = (code == CHIP_NTSC);
        dots = ntsc ? (int'(NTSC_H_MAX) + 1) / 2 : (int'(PAL_H_MAX) + 1) / 2;
        lines = ntsc ? (int'(NTSC_V_MAX) + 1) / 2 : (int'(PAL_V_MAX) + 1) / 2;
        for (int y = 0; y < lines; y++) begin
            for (int x = 0; x < dots; x++) begin
                for (int p = 0; p < 4; p++) begin
                    chip = (y < lines / 2) ? code : next_code;
                    raster_x = RASTER_X_W'(x);
                    raster_y = RASTER_Y_W'(y);
                    // phases 2 and 3 carry the odd hires pixel
                    hires_raster_x = ADDR_W'(2 * x + p / 2);
                    pixel_color3 = COLOR_W'(take_bits(COLOR_W));
                    @(negedge clk_dot4x);
                end
            end
        end
        finish_test(name, errs_before);
    endtask

    always @(posedge clk_dot4x) begin
        model_clock();
    end

    // outputs are registered, so they are settled at the falling edge
    always @(negedge clk_dot4x) begin
        logic [3:0] ef;
        int exp_period;
        ef = m_flags[PIPE_DELAY-1];
        if (m_live) begin
            n_cycles++;
            if (m_in_rst && ({hsync, vsync, active, half_bright, pixel_color4} !== 8'hc0)) begin
                report_mismatch("reset {hsync,vsync,active,half_bright,pixel_color4}",
                                32'h0c0, 32'({hsync, vsync, active, half_bright, pixel_color4}));
            end
            if (hsync !== ef[3]) report_mismatch("hsync", 32'(ef[3]), 32'(hsync));
            if (vsync !== ef[2]) report_mismatch("vsync", 32'(ef[2]), 32'(vsync));
            if (active !== ef[1]) report_mismatch("active", 32'(ef[1]), 32'(active));
            if (half_bright !== ef[0]) begin
                report_mismatch("half_bright", 32'(ef[0]), 32'(half_bright));
            end
            if (m_pix_ok && (pixel_color4 !== m_pix)) begin
                report_mismatch("pixel_color4", 32'(m_pix), 32'(pixel_color4));
            end
            // hsync pulse width and line period
            if (!hsync) begin
                low_len++;
            end
            if (!hsync && prev_hsync) begin
                exp_period = (m_chip == CHIP_NTSC) ? int'(NTSC_H_MAX) + 1 : int'(PAL_H_MAX) + 1;
                // a line spanning a chip change has no fixed length
                if (fall_seen && (fall_chip == m_chip) &&
                    (n_cycles - last_fall != exp_period)) begin
                    report_mismatch("hsync_period", 32'(exp_period), 32'(n_cycles - last_fall));
                end
                fall_seen = 1'b1;
                fall_chip = m_chip;
                last_fall = n_cycles;
            end
            if (hsync && !prev_hsync) begin
                if (low_len != HS_LEN) begin
                    report_mismatch("hsync_low_cycles", 32'(HS_LEN), 32'(low_len));
                end
                low_len = 0;
            end
            prev_hsync = hsync;
        end
    end

    initial begin
        logic [1:0] rnd_chip;
        lfsr_state = 32'ha23c_8386;
        clk_dot4x = 1'b0;
        rst = 1'b1;
        chip = CHIP_PAL;
        raster_x = '0;
        hires_raster_x = '0;
        raster_y = '0;
        pixel_color3 = '0;
        repeat (4) @(negedge clk_dot4x);
        // reset checks so far, the last one lands in the first frame
        @(posedge clk_dot4x);
        finish_test("reset state", 0);
        @(negedge clk_dot4x);
        rst = 1'b0;
        rnd_chip = 2'(take_bits(2));
        $display("random frame uses chip code %0d", rnd_chip);
        run_frame("pal frame 1", CHIP_PAL, CHIP_PAL);
        // ntsc requested mid frame, takes effect at the next frame start
        run_frame("pal frame 2", CHIP_PAL, CHIP_NTSC);
        run_frame("ntsc switch frame", CHIP_NTSC, rnd_chip);
        run_frame("random chip frame", rnd_chip, rnd_chip);
        $display("tests %0d, failed %0d, mismatches %0d, cycles checked %0d",
                 n_tests, n_failed, n_errors, n_cycles);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // worst case is the random frame landing on pal
    initial begin
        longint limit_cycles;
        limit_cycles = (longint'(5 + 3 * PAL_FRAME + NTSC_FRAME) * 12) / 10;
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* tests/scan_doubler_assertions.sv */
`timescale 1ns/10ps

module scan_doubler_assertions import scan_pkg::*; (
    input logic               clk_dot4x,
    input logic               rst,
    input logic               hsync,
    input logic               vsync,
    input logic               active,
    input logic               half_bright,
    input logic [COLOR_W-1:0] pixel_color4
);

    // same pulse width on both chips
    localparam int HS_LEN = int'(PAL_HS_END - PAL_HS_STA);

    // consecutive low samples of hsync, saturating
    logic [H_W-1:0] hs_low_cnt;

    always_ff @(posedge clk_dot4x) begin
        if (rst || hsync) begin
            hs_low_cnt <= '0;
        end else if (hs_low_cnt != '1) begin
            hs_low_cnt <= hs_low_cnt + 11'd1;
        end
    end

    hs_width: assert property (@(posedge clk_dot4x) disable iff (rst)
        int'(hs_low_cnt) <= HS_LEN)
        else $error("hsync low for more than %0d cycles", HS_LEN);

    // sync sits inside horizontal blanking
    hs_blank: assert property (@(posedge clk_dot4x) disable iff (rst) !hsync |-> !active)
        else $error("active high during hsync");

    reset_state: assert property (@(posedge clk_dot4x)
        rst |=> (hsync && vsync && !active && !half_bright && (pixel_color4 == '0)))
        else $error("outputs not in reset state after rst");

endmodule

bind scan_doubler scan_doubler_assertions u_scan_doubler_assertions (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .hsync        (hsync),
    .vsync        (vsync),
    .active       (active),
    .half_bright  (half_bright),
    .pixel_color4 (pixel_color4)
);

/* hw/scan_doubler.sv */
`timescale 1ns/10ps

module scan_doubler import scan_pkg::*; (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  logic [1:0]            chip,
    input  logic [RASTER_X_W-1:0] raster_x,
    input  logic [ADDR_W-1:0]     hires_raster_x,
    input  logic [RASTER_Y_W-1:0] raster_y,
    input  logic [COLOR_W-1:0]    pixel_color3,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output logic                  half_bright,
    output logic [COLOR_W-1:0]    pixel_color4
);

    // 1 when buffer 1 is being filled
    logic           buf_sel;
    logic           line_start;
    logic [H_W-1:0] h_count;

    // one bundle per line buffer
    line_buf_if bufs [NUM_BUFS] ();

    line_writer u_line_writer (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .raster_x       (raster_x),
        .hires_raster_x (hires_raster_x),
        .pixel_color3   (pixel_color3),
        .bufs           (bufs),
        .buf_sel        (buf_sel),
        .line_start     (line_start)
    );

    for (genvar i = 0; i < NUM_BUFS; i++) begin : g_buf
        line_ram u_line_ram (
            .clk_dot4x (clk_dot4x),
            .bus       (bufs[i])
        );
    end

    raster_timing u_raster_timing (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .chip        (chip),
        .raster_y    (raster_y),
        .line_start  (line_start),
        .h_count     (h_count),
        .hsync       (hsync),
        .vsync       (vsync),
        .active      (active),
        .half_bright (half_bright)
    );

    pixel_reader u_pixel_reader (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .h_count      (h_count),
        .buf_sel      (buf_sel),
        .bufs         (bufs),
        .pixel_color4 (pixel_color4)
    );

endmodule

/* hw/raster_timing.sv */
`timescale 1ns/10ps

module raster_timing import scan_pkg::*; (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  logic [1:0]            chip,
    input  logic [RASTER_Y_W-1:0] raster_y,
    input  logic                  line_start,
    output logic [H_W-1:0]        h_count,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output logic                  half_bright
);

    // chip in effect for the current frame
    logic [1:0]     frame_chip;
    logic           is_ntsc;
    logic [V_W-1:0] v_count;
    logic           half_bright_now;

    // timing of the latched chip
    logic [H_W-1:0] h_max;
    logic [H_W-1:0] hs_sta;
    logic [H_W-1:0] hs_end;
    logic [H_W-1:0] ha_sta;
    logic [V_W-1:0] v_max;
    logic [V_W-1:0] vs_sta;
    logic [V_W-1:0] vs_end;

    // v reload value, taken from the incoming chip
    logic [V_W-1:0] v_max_next;
    logic           frame_start;

    // flags before the alignment delay, {hsync, vsync, active, half_bright}
    logic [3:0] flags_now;
    logic [3:0] flags_pipe [PIPE_DELAY];

    assign is_ntsc = (frame_chip == CHIP_NTSC);

    assign h_max  = is_ntsc ? NTSC_H_MAX  : PAL_H_MAX;
    assign hs_sta = is_ntsc ? NTSC_HS_STA : PAL_HS_STA;
    assign hs_end = is_ntsc ? NTSC_HS_END : PAL_HS_END;
    assign ha_sta = is_ntsc ? NTSC_HA_STA : PAL_HA_STA;
    assign v_max  = is_ntsc ? NTSC_V_MAX  : PAL_V_MAX;
    assign vs_sta = is_ntsc ? NTSC_VS_STA : PAL_VS_STA;
    assign vs_end = is_ntsc ? NTSC_VS_END : PAL_VS_END;

    assign v_max_next  = (chip == CHIP_NTSC) ? NTSC_V_MAX : PAL_V_MAX;
    // input raster at 0,0
    assign frame_start = line_start && (raster_y == '0);

    // output counters, one pixel per clock
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            h_count         <= '0;
            v_count         <= PAL_V_MAX;
            frame_chip      <= CHIP_PAL;
            half_bright_now <= 1'b0;
        end else begin
            // >= so a shorter line after a chip change still wraps
            if (h_count >= h_max) begin
                h_count <= '0;
                if (v_count >= v_max) begin
                    v_count <= '0;
                    // line 0 always full brightness
                    half_bright_now <= 1'b0;
                end else begin
                    v_count         <= v_count + 1'b1;
                    half_bright_now <= ~half_bright_now;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
            // resync, next output line becomes line 0
            if (frame_start) begin
                v_count    <= v_max_next;
                frame_chip <= chip;
            end
        end
    end

    // sync pulses active low
    assign flags_now[3] = ~((h_count >= hs_sta) && (h_count < hs_end));
    assign flags_now[2] = ~((v_count >= vs_sta) && (v_count < vs_end));
    // pal blanks at the bottom, ntsc at the top
    assign flags_now[1] = (h_count >= ha_sta) &&
                          (is_ntsc ? (v_count >= NTSC_VA_STA) : (v_count <= PAL_VA_END));
    assign flags_now[0] = half_bright_now;

    // line flags up with the ram read and pixel register
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < PIPE_DELAY; i++) begin
                flags_pipe[i] <= 4'b1100;
            end
        end else begin
            flags_pipe[0] <= flags_now;
            for (int i = 1; i < PIPE_DELAY; i++) begin
                flags_pipe[i] <= flags_pipe[i-1];
            end
        end
    end

    assign hsync       = flags_pipe[PIPE_DELAY-1][3];
    assign vsync       = flags_pipe[PIPE_DELAY-1][2];
    assign active      = flags_pipe[PIPE_DELAY-1][1];
    assign half_bright = flags_pipe[PIPE_DELAY-1][0];

endmodule

/* hw/pixel_reader.sv */
`timescale 1ns/10ps

module pixel_reader import scan_pkg::*; (
    input  logic               clk_dot4x,
    input  logic               rst,
    input  logic [H_W-1:0]     h_count,
    input  logic               buf_sel,
    line_buf_if.reader         bufs [NUM_BUFS],
    output logic [COLOR_W-1:0] pixel_color4
);

    // read data gathered so it can be indexed by buf_sel
    logic [COLOR_W-1:0] rd_data [NUM_BUFS];

    for (genvar i = 0; i < NUM_BUFS; i++) begin : g_rd
        // same output position on both buffers
        assign bufs[i].rd_addr = h_count;
        assign rd_data[i]      = bufs[i].rd_data;
    end

    // second pipe stage, take the buffer not being filled
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color4 <= '0;
        end else begin
            pixel_color4 <= rd_data[!buf_sel];
        end
    end

endmodule

/* hw/line_ram.sv */
`timescale 1ns/10ps

module line_ram import scan_pkg::*; (
    input logic     clk_dot4x,
    line_buf_if.ram bus
);

    // one doubled raster line of colour indices
    logic [COLOR_W-1:0] mem [2**ADDR_W];

    // write port
    always_ff @(posedge clk_dot4x) begin
        if (bus.we) begin
            mem[bus.wr_addr] <= bus.wr_data;
        end
    end

    // registered read, data one clock after the address
    always_ff @(posedge clk_dot4x) begin
        bus.rd_data <= mem[bus.rd_addr];
    end

endmodule

/* hw/line_writer.sv */
`timescale 1ns/10ps

module line_writer import scan_pkg::*; (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    input  logic [RASTER_X_W-1:0] raster_x,
    input  logic [ADDR_W-1:0]     hires_raster_x,
    input  logic [COLOR_W-1:0]    pixel_color3,
    line_buf_if.writer            bufs [NUM_BUFS],
    output logic                  buf_sel,
    output logic                  line_start
);

    // four clocks per native dot
    logic [1:0] dot_phase;

    // phase 0 in the first cycle out of reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_phase <= 2'd0;
        end else begin
            dot_phase <= dot_phase + 2'd1;
        end
    end

    // first dot of a native line, sampled in phase 1
    assign line_start = (dot_phase == 2'd1) && (raster_x == '0);

    // swap buffers at the start of each input line
    // pixels in the swap cycle still land in the old buffer
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            buf_sel <= 1'b0;
        end else if (line_start) begin
            buf_sel <= ~buf_sel;
        end
    end

    // every clock writes, only the selected buffer enables
    for (genvar i = 0; i < NUM_BUFS; i++) begin : g_wr
        assign bufs[i].we      = (buf_sel == 1'(i));
        // hires x already doubles the native dot
        assign bufs[i].wr_addr = hires_raster_x;
        assign bufs[i].wr_data = pixel_color3;
    end

endmodule

/* hw/line_buf_if.sv */
`timescale 1ns/10ps

interface line_buf_if import scan_pkg::*; ();

    // write side, driven by the line writer
    logic               we;
    logic [ADDR_W-1:0]  wr_addr;
    logic [COLOR_W-1:0] wr_data;

    // read side, address from the reader, data from the ram
    logic [ADDR_W-1:0]  rd_addr;
    logic [COLOR_W-1:0] rd_data;

    modport ram (
        input  we, wr_addr, wr_data, rd_addr,
        output rd_data
    );

    modport writer (
        output we, wr_addr, wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

endinterface

/* hw/scan_pkg.sv */
package scan_pkg;

    // colour index and line buffer geometry
    localparam int COLOR_W = 4;
    // 1040 hires positions on the longest (ntsc) line
    localparam int ADDR_W = 11;
    localparam int NUM_BUFS = 2;

    // native raster inputs from the video chip
    localparam int RASTER_X_W = 10;
    localparam int RASTER_Y_W = 9;

    // output counters at double rate
    localparam int H_W = 11;
    localparam int V_W = 10;

    // chip codes, everything but ntsc falls back to pal
    localparam logic [1:0] CHIP_PAL = 2'd0;
    localparam logic [1:0] CHIP_NTSC = 2'd1;

    // pal 6569, 1008 x 624 output
    localparam logic [H_W-1:0] PAL_H_MAX = 11'd1007;
    localparam logic [H_W-1:0] PAL_HS_STA = 11'd20;
    localparam logic [H_W-1:0] PAL_HS_END = 11'd140;
    localparam logic [H_W-1:0] PAL_HA_STA = 11'd200;
    localparam logic [V_W-1:0] PAL_V_MAX = 10'd623;
    // pal blanking sits at the bottom of the frame
    localparam logic [V_W-1:0] PAL_VA_END = 10'd591;
    localparam logic [V_W-1:0] PAL_VS_STA = 10'd601;
    localparam logic [V_W-1:0] PAL_VS_END = 10'd604;

    // ntsc 6567r8, 1040 x 526 output
    localparam logic [H_W-1:0] NTSC_H_MAX = 11'd1039;
    localparam logic [H_W-1:0] NTSC_HS_STA = 11'd20;
    localparam logic [H_W-1:0] NTSC_HS_END = 11'd140;
    localparam logic [H_W-1:0] NTSC_HA_STA = 11'd160;
    localparam logic [V_W-1:0] NTSC_V_MAX = 10'd525;
    // ntsc blanking sits at the top of the frame
    localparam logic [V_W-1:0] NTSC_VS_STA = 10'd70;
    localparam logic [V_W-1:0] NTSC_VS_END = 10'd72;
    localparam logic [V_W-1:0] NTSC_VA_STA = 10'd76;

    // read address to pixel pin: ram read plus output register
    localparam int PIPE_DELAY = 2;

endpackage
